/* Bender.yml */
package:
  name: lmem_port

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lmem_bus_pkg.sv
      - hdl/lmem_csr_pkg.sv
      - hdl/lmem_csr_regs.sv
      - hdl/lmem_cmd_engine.sv
      - hdl/lmem_bank.sv
      - hdl/lmem_port_top.sv
  - target: test
    files:
      - test/tb_lmem_port.sv

/* hdl/lmem_bank.sv */
//##########################################################
// Behavioral memory bank standing in for the memory
// controller. Byte-enabled line writes, a waitrequest window
// after every accepted request and fixed read latency.
//##########################################################

`timescale 1ns/1ns
`default_nettype none

`include "lmem_consts.svh"

module lmem_bank
#(
    parameter int BUSY_CYCLES = 1
)
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire lmem_bus_pkg::lmem_req_t  req,
    output lmem_bus_pkg::lmem_rsp_t       rsp
);
    import lmem_bus_pkg::*;

    localparam int CNT_W  = $clog2(BUSY_CYCLES + 2);
    localparam int LAT    = `LMEM_RD_LATENCY;
    localparam int NBYTES = `LMEM_LINE_W / 8;

    logic [`LMEM_LINE_W-1:0] mem [2**`LMEM_ADDR_W];
    logic [CNT_W-1:0]        busy_cnt;
    logic [LAT-1:0]          rd_pipe;
    logic [`LMEM_LINE_W-1:0] data_pipe [LAT];
    logic                    accept;

    assign accept = (req.read || req.write) && (busy_cnt == '0);

    // Countdown for the wait window
    always_ff @(posedge clk)
    begin
        if (reset)
            busy_cnt <= '0;
        else if (accept)
            busy_cnt <= CNT_W'(BUSY_CYCLES);
        else if (busy_cnt != '0)
            busy_cnt <= busy_cnt - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (accept && req.write)
        begin
            for (int i = 0; i < NBYTES; i++)
            begin
                if (req.byteenable[i])
                    mem[req.address][i*8 +: 8] <= req.writedata[i*8 +: 8];
            end
        end
    end

    // Read delay line, stage 0 loads on the accepting edge
    always_ff @(posedge clk)
    begin
        if (reset)
            rd_pipe <= '0;
        else
        begin
            rd_pipe[0] <= accept && req.read;
            for (int i = 1; i < LAT; i++)
                rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        data_pipe[0] <= mem[req.address];
        for (int i = 1; i < LAT; i++)
            data_pipe[i] <= data_pipe[i-1];
    end

    assign rsp.waitrequest   = (busy_cnt != '0);
    assign rsp.readdatavalid = rd_pipe[LAT-1];
    assign rsp.readdata      = data_pipe[LAT-1];

endmodule

`default_nettype wire

/* hdl/lmem_bus_pkg.sv */
//##########################################################
// Bank-side bus types: one request beat from the command
// engine to a bank and the response the bank returns.
//##########################################################

`default_nettype none

`include "lmem_consts.svh"

package lmem_bus_pkg;

    // One Avalon-style request beat, held while waitrequest is high
    typedef struct packed {
        logic                         read;
        logic                         write;
        logic [`LMEM_ADDR_W-1:0]      address;
        logic [`LMEM_LINE_W-1:0]      writedata;
        logic [`LMEM_LINE_W/8-1:0]    byteenable;
    } lmem_req_t;

    // Bank response, readdata only meaningful with readdatavalid
    typedef struct packed {
        logic                         waitrequest;
        logic                         readdatavalid;
        logic [`LMEM_LINE_W-1:0]      readdata;
    } lmem_rsp_t;

endpackage

`default_nettype wire

/* hdl/lmem_cmd_engine.sv */
//##########################################################
// Runs one host command at a time against the banks. Holds
// the bank request until accepted and keeps the sticky read
// result that the register block reports.
//##########################################################

`timescale 1ns/1ns
`default_nettype none

`include "lmem_consts.svh"

module lmem_cmd_engine
(
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire lmem_csr_pkg::lmem_cmd_t   cmd,
    input  wire logic                      cmd_valid,
    output lmem_csr_pkg::lmem_result_t     result,
    output lmem_bus_pkg::lmem_req_t        bank_req [`LMEM_NUM_BANKS],
    input  wire lmem_bus_pkg::lmem_rsp_t   bank_rsp [`LMEM_NUM_BANKS]
);
    import lmem_csr_pkg::*;
    import lmem_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT_RD
    } state_e;

    typedef logic [`LMEM_LINE_WORDS-1:0][63:0] line_words_t;

    state_e      state;
    lmem_cmd_t   cmd_q;
    logic        rd_valid;
    logic [63:0] rdata;
    logic        cmd_ok;
    logic        sel_wait;
    logic        sel_rvalid;
    line_words_t sel_line;

    // Only real opcodes start work, anything arriving while busy is lost
    assign cmd_ok = cmd_valid && (state == ST_IDLE) &&
                    ((cmd.op == OP_READ) || (cmd.op == OP_WRITE));

    // Response of the bank the current command targets
    always_comb
    begin
        sel_wait   = bank_rsp[cmd_q.bank].waitrequest;
        sel_rvalid = bank_rsp[cmd_q.bank].readdatavalid;
        sel_line   = line_words_t'(bank_rsp[cmd_q.bank].readdata);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= ST_IDLE;
            rd_valid <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (cmd_ok)
                    begin
                        state <= ST_REQ;
                        if (cmd.op == OP_READ)
                            rd_valid <= 1'b0;
                    end
                end
                ST_REQ:
                begin
                    // Accepted on an edge without waitrequest
                    if (!sel_wait)
                        state <= (cmd_q.op == OP_READ) ? ST_WAIT_RD : ST_IDLE;
                end
                ST_WAIT_RD:
                begin
                    if (sel_rvalid)
                    begin
                        state    <= ST_IDLE;
                        rd_valid <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_ok)
            cmd_q <= cmd;
        if ((state == ST_WAIT_RD) && sel_rvalid)
            rdata <= sel_line[cmd_q.word_sel];
    end

    assign result.busy     = (state != ST_IDLE);
    assign result.rd_valid = rd_valid;
    assign result.rdata    = rdata;

    // Strobe only the addressed bank, payload is broadcast
    for (genvar b = 0; b < `LMEM_NUM_BANKS; b++)
    begin : g_req
        always_comb
        begin
            bank_req[b].read       = (state == ST_REQ) && (cmd_q.op == OP_READ) &&
                                     (int'(cmd_q.bank) == b);
            bank_req[b].write      = (state == ST_REQ) && (cmd_q.op == OP_WRITE) &&
                                     (int'(cmd_q.bank) == b);
            bank_req[b].address    = cmd_q.addr;
            bank_req[b].writedata  = {`LMEM_LINE_WORDS{cmd_q.wdata}};
            bank_req[b].byteenable = {`LMEM_LINE_WORDS{cmd_q.be}};
        end
    end

endmodule

`default_nettype wire

/* hdl/lmem_consts.svh */
//##########################################################
// Sizes and timing constants for the local memory test port.
// Included by the packages and by any module that sizes logic
// from them.
//##########################################################

`ifndef LMEM_CONSTS_SVH
`define LMEM_CONSTS_SVH

// Bank organisation
`define LMEM_NUM_BANKS      2
`define LMEM_BANK_IDX_W     1
`define LMEM_ADDR_W         8

// Line layout, built from 64-bit words
`define LMEM_LINE_WORDS     2
`define LMEM_WORD_SEL_W     1
`define LMEM_LINE_W         128

// Bank timing in clock cycles
`define LMEM_RD_LATENCY     3
`define LMEM_BUSY_BANK0     1
`define LMEM_BUSY_BANK1     3

`endif

/* hdl/lmem_csr_pkg.sv */
//##########################################################
// Host-side types: register map, command opcodes, the
// decoded command and the result seen by the host.
//##########################################################

`default_nettype none

`include "lmem_consts.svh"

package lmem_csr_pkg;

    // Wishbone word addresses
    typedef enum logic [2:0] {
        REG_ADDR   = 3'd0,
        REG_WDATA  = 3'd1,
        REG_CMD    = 3'd2,
        REG_STATUS = 3'd3,
        REG_RDATA  = 3'd4
    } lmem_reg_e;

    // Opcode in CMD bits 1:0, bit 0 read and bit 1 write
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } lmem_op_e;

    typedef struct packed {
        lmem_op_e                     op;
        logic [`LMEM_BANK_IDX_W-1:0]  bank;
        logic [7:0]                   be;
        logic [`LMEM_WORD_SEL_W-1:0]  word_sel;
        logic [`LMEM_ADDR_W-1:0]      addr;
        logic [63:0]                  wdata;
    } lmem_cmd_t;

    typedef struct packed {
        logic        busy;
        logic        rd_valid;
        logic [63:0] rdata;
    } lmem_result_t;

endpackage

`default_nettype wire

/* hdl/lmem_csr_regs.sv */
//##########################################################
// Wishbone classic register block for the memory test port.
// Holds ADDR, WDATA and CMD and fires one cmd_valid pulse
// per accepted command write.
//##########################################################

`timescale 1ns/1ns
`default_nettype none

`include "lmem_consts.svh"

module lmem_csr_regs
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       wb_cyc,
    input  wire logic                       wb_stb,
    input  wire logic                       wb_we,
    input  wire logic [2:0]                 wb_adr,
    input  wire logic [63:0]                wb_dat_w,
    input  wire lmem_csr_pkg::lmem_result_t result,
    output logic [63:0]                     wb_dat_r,
    output logic                            wb_ack,
    output lmem_csr_pkg::lmem_cmd_t         cmd,
    output logic                            cmd_valid
);
    import lmem_csr_pkg::*;

    logic [63:0] addr_reg;
    logic [63:0] wdata_reg;
    logic [63:0] cmd_reg;
    logic [63:0] status;
    logic [63:0] rd_mux;
    lmem_reg_e   reg_sel;
    logic        wb_hit;
    logic        wr_hit;

    // A new strobe is served once, ack blocks a repeat hit
    assign wb_hit  = wb_cyc && wb_stb && !wb_ack;
    assign wr_hit  = wb_hit && wb_we;
    assign reg_sel = lmem_reg_e'(wb_adr);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_ack    <= 1'b0;
            cmd_valid <= 1'b0;
            addr_reg  <= '0;
            wdata_reg <= '0;
            cmd_reg   <= '0;
        end
        else
        begin
            wb_ack    <= wb_hit;
            cmd_valid <= wr_hit && (reg_sel == REG_CMD) &&
                         (lmem_op_e'(wb_dat_w[1:0]) != OP_NONE);
            if (wr_hit)
            begin
                case (reg_sel)
                    REG_ADDR:  addr_reg  <= wb_dat_w;
                    REG_WDATA: wdata_reg <= wb_dat_w;
                    REG_CMD:   cmd_reg   <= wb_dat_w;
                    // STATUS, RDATA and holes ignore writes
                    default:   ;
                endcase
            end
        end
    end

    always_comb
    begin
        status        = '0;
        status[0]     = result.rd_valid;
        status[1]     = result.busy;
        status[63:56] = 8'(`LMEM_NUM_BANKS);
    end

    always_comb
    begin
        case (reg_sel)
            REG_ADDR:   rd_mux = addr_reg;
            REG_WDATA:  rd_mux = wdata_reg;
            REG_CMD:    rd_mux = cmd_reg;
            REG_STATUS: rd_mux = status;
            REG_RDATA:  rd_mux = result.rdata;
            default:    rd_mux = '0;
        endcase
    end

    // Read data lands on the same edge as ack
    always_ff @(posedge clk)
    begin
        if (wb_hit && !wb_we)
            wb_dat_r <= rd_mux;
    end

    // Field split of the CMD word
    always_comb
    begin
        cmd.op       = lmem_op_e'(cmd_reg[1:0]);
        cmd.bank     = cmd_reg[2 +: `LMEM_BANK_IDX_W];
        cmd.be       = cmd_reg[11:4];
        cmd.word_sel = cmd_reg[16 +: `LMEM_WORD_SEL_W];
        cmd.addr     = addr_reg[`LMEM_ADDR_W-1:0];
        cmd.wdata    = wdata_reg;
    end

endmodule

`default_nettype wire

/* hdl/lmem_port_top.sv */
//##########################################################
// Top of the local memory test port: Wishbone registers,
// command engine and one behavioral bank per bank index.
//##########################################################

`timescale 1ns/1ns
`default_nettype none

`include "lmem_consts.svh"

module lmem_port_top
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [2:0]  wb_adr,
    input  wire logic [63:0] wb_dat_w,
    output logic [63:0]      wb_dat_r,
    output logic             wb_ack
);
    import lmem_csr_pkg::*;
    import lmem_bus_pkg::*;

    lmem_cmd_t    cmd;
    logic         cmd_valid;
    lmem_result_t result;
    lmem_req_t    bank_req [`LMEM_NUM_BANKS];
    lmem_rsp_t    bank_rsp [`LMEM_NUM_BANKS];

    lmem_csr_regs u_csr_regs (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .result    (result),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    lmem_cmd_engine u_cmd_engine (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .result    (result),
        .bank_req  (bank_req),
        .bank_rsp  (bank_rsp)
    );

    // Bank 0 is the fast one
    for (genvar b = 0; b < `LMEM_NUM_BANKS; b++)
    begin : g_bank
        lmem_bank #(
            .BUSY_CYCLES ((b == 0) ? `LMEM_BUSY_BANK0 : `LMEM_BUSY_BANK1)
        ) u_bank (
            .clk   (clk),
            .reset (reset),
            .req   (bank_req[b]),
            .rsp   (bank_rsp[b])
        );
    end

endmodule

`default_nettype wire

/* lmem_port.f */
+incdir+hdl
hdl/lmem_bus_pkg.sv
hdl/lmem_csr_pkg.sv
hdl/lmem_csr_regs.sv
hdl/lmem_cmd_engine.sv
hdl/lmem_bank.sv
hdl/lmem_port_top.sv
test/tb_lmem_port.sv

/* test/tb_lmem_port.sv */
//##########################################################
// Self-checking testbench for the local memory test port.
// Drives the Wishbone registers and checks bank contents
// against a byte-merge model of every bank line.
//##########################################################

`timescale 1ns/1ns
`default_nettype none

`include "lmem_consts.svh"

module tb_lmem_port;
    import lmem_csr_pkg::*;

    localparam int ACK_LIMIT  = 20;
    localparam int POLL_LIMIT = 50;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [63:0] wb_dat_w;
    logic [63:0] wb_dat_r;
    logic        wb_ack;
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    logic        timeout_hit;
    // One entry per bank, line and 64-bit word
    logic [63:0] model_mem [0:1023];

    lmem_port_top u_lmem_port_top (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [63:0] r);
        rng_state = xorshift32(rng_state);
        r[63:32]  = rng_state;
        rng_state = xorshift32(rng_state);
        r[31:0]   = rng_state;
    endtask

    function automatic int model_idx(input int bank, input int addr, input int word);
        return bank * 512 + addr * 2 + word;
    endfunction

    // Enabled bytes take the new data and the rest keep the old line
    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0]  be);
        logic [63:0] res;
        res = old_word;
        for (int j = 0; j < 8; j++)
        begin
            if (be[j])
                res[j*8 +: 8] = new_word[j*8 +: 8];
        end
        return res;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // Stalls this process so the watcher below ends the run
    task automatic stop_on_timeout(input string msg);
        $display("Timeout: %s", msg);
        errors++;
        timeout_hit = 1'b1;
        forever @(posedge clk);
    endtask

    task automatic wb_cycle(input logic we, input logic [2:0] adr,
                            input logic [63:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        @(negedge clk);
        while (!wb_ack)
        begin
            waited++;
            if (waited > ACK_LIMIT)
                stop_on_timeout("Wishbone slave never raised ack");
            @(negedge clk);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [63:0] data);
        wb_cycle(1'b1, adr, data);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [63:0] data);
        wb_cycle(1'b0, adr, 64'd0);
        data = wb_dat_r;
    endtask

    task automatic wait_idle(output logic [63:0] status);
        int polls;
        polls = 0;
        wb_read(REG_STATUS, status);
        while (status[1])
        begin
            polls++;
            if (polls > POLL_LIMIT)
                stop_on_timeout("busy flag never cleared");
            wb_read(REG_STATUS, status);
        end
    endtask

    task automatic mem_write(input int bank, input int addr, input logic [7:0] be,
                             input logic [63:0] data);
        logic [63:0] cmd_word;
        logic [63:0] status;
        cmd_word       = '0;
        cmd_word[1:0]  = OP_WRITE;
        cmd_word[3:2]  = 2'(bank);
        cmd_word[11:4] = be;
        wb_write(REG_ADDR, 64'(addr));
        wb_write(REG_WDATA, data);
        wb_write(REG_CMD, cmd_word);
        wait_idle(status);
        for (int w = 0; w < `LMEM_LINE_WORDS; w++)
            model_mem[model_idx(bank, addr, w)] =
                merge_bytes(model_mem[model_idx(bank, addr, w)], data, be);
    endtask

    task automatic mem_read(input int bank, input int addr, input int word,
                            output logic [63:0] data, output logic rv);
        logic [63:0] cmd_word;
        logic [63:0] status;
        cmd_word       = '0;
        cmd_word[1:0]  = OP_READ;
        cmd_word[3:2]  = 2'(bank);
        cmd_word[16]   = word[0];
        wb_write(REG_ADDR, 64'(addr));
        wb_write(REG_CMD, cmd_word);
        // A read in flight shows busy with read valid cleared
        wb_read(REG_STATUS, status);
        check_value(64'(status[1:0]), 64'd2, "status while read in flight");
        wait_idle(status);
        rv = status[0];
        wb_read(REG_RDATA, data);
    endtask

    task automatic report_and_finish();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    endtask

    initial
    begin
        wait (timeout_hit);
        report_and_finish();
    end

    initial
    begin
        logic [63:0] rnd;
        logic [63:0] data;
        logic [63:0] got;
        logic        rv;
        int          bank;
        int          addr;
        clk         = 1'b0;
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        rng_state   = 32'h8de3_f509;
        errors      = 0;
        checks      = 0;
        timeout_hit = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Status after reset
        wb_read(REG_STATUS, got);
        check_value(64'(got[1]), 64'd0, "busy after reset");
        check_value(64'(got[0]), 64'd0, "read valid after reset");
        check_value(64'(got[63:56]), 64'(`LMEM_NUM_BANKS), "bank count");

        // Register readback and unmapped holes
        draw_random(data);
        wb_write(REG_ADDR, data);
        wb_read(REG_ADDR, got);
        check_value(got, data, "ADDR readback");
        draw_random(data);
        wb_write(REG_WDATA, data);
        wb_read(REG_WDATA, got);
        check_value(got, data, "WDATA readback");
        for (int a = 5; a < 8; a++)
        begin
            wb_read(3'(a), got);
            check_value(got, 64'd0, "unmapped address read");
        end

        // Full-enable writes in both banks with every word read back
        for (int i = 0; i < 8; i++)
        begin
            draw_random(rnd);
            bank = i % 2;
            addr = int'(rnd[7:0]);
            draw_random(data);
            mem_write(bank, addr, 8'hff, data);
            for (int w = 0; w < `LMEM_LINE_WORDS; w++)
            begin
                mem_read(bank, addr, w, got, rv);
                check_value(64'(rv), 64'd1, "read valid when busy fell");
                check_value(got, model_mem[model_idx(bank, addr, w)], "full write readback");
            end
        end

        // Partial byte enables merge into the old line
        for (int i = 0; i < 6; i++)
        begin
            draw_random(rnd);
            bank = int'(rnd[8]);
            addr = int'(rnd[7:0]);
            draw_random(data);
            mem_write(bank, addr, 8'hff, data);
            for (int k = 0; k < 2; k++)
            begin
                draw_random(rnd);
                draw_random(data);
                mem_write(bank, addr, rnd[7:0], data);
            end
            for (int w = 0; w < `LMEM_LINE_WORDS; w++)
            begin
                mem_read(bank, addr, w, got, rv);
                check_value(got, model_mem[model_idx(bank, addr, w)], "byte merge readback");
            end
        end

        // Same line in both banks stays independent
        draw_random(rnd);
        addr = int'(rnd[7:0]);
        draw_random(data);
        mem_write(0, addr, 8'hff, data);
        mem_write(1, addr, 8'hff, ~data);
        for (int b = 0; b < `LMEM_NUM_BANKS; b++)
        begin
            for (int w = 0; w < `LMEM_LINE_WORDS; w++)
            begin
                mem_read(b, addr, w, got, rv);
                check_value(got, model_mem[model_idx(b, addr, w)], "bank routing");
            end
        end

        report_and_finish();
    end

endmodule

`default_nettype wire
